// File: Makefile
# Verilator flow for the VSA subsystem, any variable can be set on the command line
VERILATOR ?= verilator
TOP       ?= vsaSystemTb
RTL_TOP   ?= vsaSystem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary -j 0 --timescale $(TIMESCALE)
PASS_TEXT ?= PASS: all tests

SOURCES     := $(shell cat $(FILELIST))
RTL_SOURCES := $(filter source/%,$(SOURCES))
SIM_BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(RTL_SOURCES) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
source/vsaPkg.sv
source/vsaRegFile.sv
source/vsaAlu.sv
source/vsaCore.sv
source/vsaMemory.sv
source/vsaSystem.sv
tb/vsaSystemTb.sv

// File: source/vsaAlu.sv
/* Combinational ALU, all arithmetic wraps modulo 32.
   Result for undefined opcodes is zero. */
module vsaAlu (
    input  vsaPkg::vsaInstr                 instr,
    input  logic [vsaPkg::dataWidth-1:0]    operandA,
    input  logic [vsaPkg::dataWidth-1:0]    operandB,
    input  logic [vsaPkg::dataWidth-1:0]    nextPc,
    output logic [vsaPkg::dataWidth-1:0]    result,
    output logic                            zeroFlag
);

    logic [vsaPkg::dataWidth-1:0] imm;
    logic [vsaPkg::dataWidth-1:0] branchOffset;

    assign imm          = instr.i.immediate;
    assign branchOffset = {instr.i.immediate[3:0], 1'b0};  // low four bits, times two

    always_comb begin
        result = '0;
        case (instr.r.opcode)
            vsaPkg::opLoad,
            vsaPkg::opStore:      result = operandA + imm;          // effective address
            vsaPkg::opAddImm:     result = operandA + imm;
            vsaPkg::opSubImm:     result = operandA - imm;
            vsaPkg::opBranchZero: result = nextPc + branchOffset;   // taken target
            vsaPkg::opAluReg: begin
                case (instr.r.funct)
                    vsaPkg::funAdd:        result = operandA + operandB;
                    vsaPkg::funSub:        result = operandA - operandB;
                    vsaPkg::funAnd:        result = operandA & operandB;
                    vsaPkg::funOr:         result = operandA | operandB;
                    vsaPkg::funXor:        result = operandA ^ operandB;
                    vsaPkg::funNot:        result = ~operandA;      // B unused
                    vsaPkg::funShiftRight: result = {1'b0, operandA[4:1]};
                    vsaPkg::funShiftArith: result = {operandA[4], operandA[4:1]};
                    default:               result = '0;
                endcase
            end
            default:              result = '0;
        endcase
    end

    // branch condition, sampled by the core in execute
    assign zeroFlag = (operandA == '0);

endmodule

// File: source/vsaCore.sv
/* Non-pipelined five-state core, every instruction takes exactly 5 cycles.
   Store strobe is a level during the memory state only, no handshake.
   Undefined opcodes 6 and 7 just advance the pc. */
module vsaCore (
    input  logic                            clock,
    input  logic                            reset,
    input  vsaPkg::vsaInstr                 instruction,  // from instruction memory
    output logic [vsaPkg::dataWidth-1:0]    pc,
    input  logic [vsaPkg::dataWidth-1:0]    dataIn,       // data memory read at address
    output vsaPkg::vsaDataWrite             dataWrite
);

    vsaPkg::vsaState                 state;
    logic [vsaPkg::dataWidth-1:0]    npc;        // pc + 2
    vsaPkg::vsaInstr                 ir;
    logic [vsaPkg::dataWidth-1:0]    a;          // first operand
    logic [vsaPkg::dataWidth-1:0]    b;          // second operand, also store data
    logic [vsaPkg::dataWidth-1:0]    aluOutput;  // address, result or branch target
    logic                            cond;       // branch taken
    logic [vsaPkg::dataWidth-1:0]    lmd;        // load data

    // register file and alu hookup
    logic [vsaPkg::dataWidth-1:0]    readA;
    logic [vsaPkg::dataWidth-1:0]    readB;
    logic                            regWrite;
    logic [vsaPkg::regSelWidth-1:0]  regWriteSel;
    logic [vsaPkg::dataWidth-1:0]    regWriteData;
    logic [vsaPkg::dataWidth-1:0]    aluResult;
    logic                            zeroFlag;

    // opcode classes, decoded once from ir
    logic isLoad;
    logic isStore;
    logic isBranch;
    logic isRegReg;
    logic isRegImm;
    logic isKnown;

    assign isLoad   = (ir.r.opcode == vsaPkg::opLoad);
    assign isStore  = (ir.r.opcode == vsaPkg::opStore);
    assign isBranch = (ir.r.opcode == vsaPkg::opBranchZero);
    assign isRegReg = (ir.r.opcode == vsaPkg::opAluReg);
    assign isRegImm = (ir.r.opcode == vsaPkg::opAddImm) || (ir.r.opcode == vsaPkg::opSubImm);
    assign isKnown  = isLoad || isStore || isBranch || isRegReg || isRegImm;

    vsaRegFile regFile (
        .clock       (clock),
        .reset       (reset),
        .readSelA    (ir.r.source1),
        .readSelB    (ir.r.source2),
        .readA       (readA),
        .readB       (readB),
        .writeEnable (regWrite),
        .writeSel    (regWriteSel),
        .writeData   (regWriteData)
    );

    vsaAlu alu (
        .instr    (ir),
        .operandA (a),
        .operandB (b),
        .nextPc   (npc),
        .result   (aluResult),
        .zeroFlag (zeroFlag)
    );

    // sequencer, wraps after write-back
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= vsaPkg::stateFetch;
        end else begin
            case (state)
                vsaPkg::stateFetch:     state <= vsaPkg::stateDecode;
                vsaPkg::stateDecode:    state <= vsaPkg::stateExecute;
                vsaPkg::stateExecute:   state <= vsaPkg::stateMemory;
                vsaPkg::stateMemory:    state <= vsaPkg::stateWriteBack;
                default:                state <= vsaPkg::stateFetch;
            endcase
        end
    end

    // datapath registers, each loaded in exactly one state
    always_ff @(posedge clock) begin
        if (reset) begin
            pc        <= '0;
            npc       <= '0;
            ir        <= '0;
            a         <= '0;
            b         <= '0;
            aluOutput <= '0;
            cond      <= 1'b0;
            lmd       <= '0;
        end else begin
            case (state)
                vsaPkg::stateFetch: begin
                    npc <= pc + 5'd2;
                    ir  <= instruction;
                end
                vsaPkg::stateDecode: begin
                    a <= readA;
                    b <= readB;
                end
                vsaPkg::stateExecute: begin
                    if (isKnown) begin
                        aluOutput <= aluResult;     // held for undefined opcodes
                    end
                    if (isBranch) begin
                        cond <= zeroFlag;
                    end
                end
                vsaPkg::stateMemory: begin
                    if (isLoad) begin
                        lmd <= dataIn;              // combinational read at aluOutput
                    end
                    pc <= (isBranch && cond) ? aluOutput : npc;
                end
                default: ;                          // write-back goes through the register file
            endcase
        end
    end

    // write-back select
    // R-format uses rd, I-format reuses the source2 slot
    assign regWrite     = (state == vsaPkg::stateWriteBack) && (isRegReg || isRegImm || isLoad);
    assign regWriteSel  = isRegReg ? ir.r.destination : ir.i.destination;
    assign regWriteData = isLoad ? lmd : aluOutput;

    assign dataWrite.wr      = (state == vsaPkg::stateMemory) && isStore;
    assign dataWrite.address = aluOutput;
    assign dataWrite.data    = b;

endmodule

// File: source/vsaMemory.sv
/* 32-word memory, combinational read and one synchronous write port.
   No reset, contents survive reset and must be preloaded. */
module vsaMemory #(
    parameter int wordWidth = 12           // 12 for program, 5 for data
) (
    input  logic                            clock,
    input  logic [vsaPkg::dataWidth-1:0]    readAddress,
    output logic [wordWidth-1:0]            readData,
    input  logic                            writeEnable,
    input  logic [vsaPkg::dataWidth-1:0]    writeAddress,
    input  logic [wordWidth-1:0]            writeData
);

    logic [wordWidth-1:0] mem [vsaPkg::memDepth];

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            mem[writeAddress] <= writeData;
        end
    end

    // read sees the old word when read and write hit the same address
    assign readData = mem[readAddress];

endmodule

// File: source/vsaPkg.sv
/* Shared types for the 12-bit VSA subsystem. Opcodes 6 and 7 are undefined
   and execute as no-ops. R-format source2 and I-format destination share bits. */
package vsaPkg;

    localparam int dataWidth   = 5;                  // datapath, pc and memory address
    localparam int instrWidth  = 12;
    localparam int memDepth    = 32;                 // words per memory
    localparam int regCount    = 4;                  // R0 hardwired to zero
    localparam int regSelWidth = $clog2(regCount);

    // one-hot would be wider, binary keeps the reference encoding
    typedef enum logic [2:0] {
        stateFetch     = 3'd0,
        stateDecode    = 3'd1,
        stateExecute   = 3'd2,
        stateMemory    = 3'd3,
        stateWriteBack = 3'd4
    } vsaState;

    typedef enum logic [2:0] {
        opLoad       = 3'd0,   // LW
        opStore      = 3'd1,   // SW
        opBranchZero = 3'd2,   // BEQZ
        opAluReg     = 3'd3,   // R-format group
        opAddImm     = 3'd4,   // ADDI
        opSubImm     = 3'd5    // SUBI
    } vsaOpcode;

    typedef enum logic [2:0] {
        funAdd        = 3'd0,
        funSub        = 3'd1,
        funAnd        = 3'd2,
        funOr         = 3'd3,
        funXor        = 3'd4,
        funNot        = 3'd5,  // B ignored
        funShiftRight = 3'd6,  // logical, by one
        funShiftArith = 3'd7   // arithmetic, by one
    } vsaFunction;

    typedef struct packed {
        vsaOpcode                 opcode;        // [11:9]
        logic [regSelWidth-1:0]   source1;       // [8:7]
        logic [regSelWidth-1:0]   source2;       // [6:5]
        logic [regSelWidth-1:0]   destination;   // [4:3]
        vsaFunction               funct;         // [2:0]
    } vsaRFormat;

    typedef struct packed {
        vsaOpcode                 opcode;
        logic [regSelWidth-1:0]   source1;
        logic [regSelWidth-1:0]   destination;   // same bits as r.source2
        logic [dataWidth-1:0]     immediate;     // zero extended in effect
    } vsaIFormat;

    // one word, two views
    typedef union packed {
        vsaRFormat r;
        vsaIFormat i;
    } vsaInstr;

    // data store request, also the system result port
    typedef struct packed {
        logic                     wr;
        logic [dataWidth-1:0]     address;
        logic [dataWidth-1:0]     data;
    } vsaDataWrite;

    typedef struct packed {
        logic                     valid;
        logic [dataWidth-1:0]     address;
        vsaInstr                  instr;
    } vsaProgLoad;

    typedef struct packed {
        logic                     valid;
        logic [dataWidth-1:0]     address;
        logic [dataWidth-1:0]     data;
    } vsaDataLoad;

endpackage

// File: source/vsaRegFile.sv
/* Four 5-bit registers, two combinational read ports, one write port.
   Writes to index 0 are dropped so R0 always reads zero. */
module vsaRegFile (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [vsaPkg::regSelWidth-1:0]     readSelA,
    input  logic [vsaPkg::regSelWidth-1:0]     readSelB,
    output logic [vsaPkg::dataWidth-1:0]       readA,
    output logic [vsaPkg::dataWidth-1:0]       readB,
    input  logic                               writeEnable,
    input  logic [vsaPkg::regSelWidth-1:0]     writeSel,
    input  logic [vsaPkg::dataWidth-1:0]       writeData
);

    logic [vsaPkg::dataWidth-1:0] regs [vsaPkg::regCount];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < vsaPkg::regCount; i++) begin
                regs[i] <= '0;                    // all registers start at zero
            end
        end else if (writeEnable && (writeSel != '0)) begin
            regs[writeSel] <= writeData;          // R0 stays zero
        end
    end

    // reads are plain muxes, no bypass of the write in flight
    assign readA = regs[readSelA];
    assign readB = regs[readSelB];

endmodule

// File: source/vsaSystem.sv
/* Core with instruction and data memories. Load ports are meant for use
   while reset is held, nothing here enforces that.
   Results are only visible through storeOut. */
module vsaSystem (
    input  logic                            clock,
    input  logic                            reset,
    input  vsaPkg::vsaProgLoad              progLoad,
    input  vsaPkg::vsaDataLoad              dataLoad,
    output vsaPkg::vsaDataWrite             storeOut,
    output logic [vsaPkg::dataWidth-1:0]    pc
);

    vsaPkg::vsaInstr                 fetchWord;
    vsaPkg::vsaDataWrite             coreWrite;
    logic [vsaPkg::dataWidth-1:0]    loadData;    // data memory read, feeds lmd

    // data memory write port, load port wins when both are active
    logic                            dataWe;
    logic [vsaPkg::dataWidth-1:0]    dataWa;
    logic [vsaPkg::dataWidth-1:0]    dataWd;

    assign dataWe = dataLoad.valid | coreWrite.wr;
    assign dataWa = dataLoad.valid ? dataLoad.address : coreWrite.address;
    assign dataWd = dataLoad.valid ? dataLoad.data : coreWrite.data;

    vsaCore core (
        .clock       (clock),
        .reset       (reset),
        .instruction (fetchWord),
        .pc          (pc),
        .dataIn      (loadData),
        .dataWrite   (coreWrite)
    );

    // program store, only written through the load port
    vsaMemory #(.wordWidth(vsaPkg::instrWidth)) instrMem (
        .clock        (clock),
        .readAddress  (pc),
        .readData     (fetchWord),
        .writeEnable  (progLoad.valid),
        .writeAddress (progLoad.address),
        .writeData    (progLoad.instr)
    );

    vsaMemory #(.wordWidth(vsaPkg::dataWidth)) dataMem (
        .clock        (clock),
        .readAddress  (coreWrite.address),   // aluOutput, same address for LW and SW
        .readData     (loadData),
        .writeEnable  (dataWe),
        .writeAddress (dataWa),
        .writeData    (dataWd)
    );

    assign storeOut = coreWrite;              // one-cycle level in the memory state

endmodule

// File: tb/vsaSystemTb.sv
/* Directed tests for vsaSystem, checked against an instruction-level model.
   Programs use even addresses only and the data preload covers words 0 to 15.
   Every test reloads both memories while reset is held. */
module vsaSystemTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clockPeriod = 20;
    localparam int resetCycles = 16;     // one preload word per reset cycle
    localparam int lenReset    = 8;
    localparam int lenImm      = 10;
    localparam int lenAlu      = 10;     // two runs, four function codes each
    localparam int lenLoad     = 6;
    localparam int lenBranch   = 6;      // instructions actually executed
    localparam int lenZero     = 7;
    localparam int runCount    = 7;
    localparam int runInstr    = lenReset + lenImm + 2 * lenAlu + lenLoad + lenBranch + lenZero;
    localparam int watchdogCycles = runCount * (resetCycles + 10) + 5 * runInstr + 100;

    logic                clock;
    logic                reset;
    vsaPkg::vsaProgLoad  progLoad;
    vsaPkg::vsaDataLoad  dataLoad;
    vsaPkg::vsaDataWrite storeOut;
    logic [4:0]          pc;

    // model state, data memory persists across resets like the DUT
    logic [4:0]      modelRegs [4];
    logic [4:0]      modelMem [32];
    logic [4:0]      modelPc;
    vsaPkg::vsaInstr progImage [32];
    logic [4:0]      dataImage [resetCycles];
    int progLen;
    int seed = 78502;
    int errorCount = 0;
    int testCount = 0;
    int failedTests = 0;

    vsaSystem uut (.clock(clock), .reset(reset), .progLoad(progLoad), .dataLoad(dataLoad),
                   .storeOut(storeOut), .pc(pc));

    always #(clockPeriod / 2) clock = ~clock;

    function automatic logic [4:0] randWord();
        int r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic vsaPkg::vsaInstr encodeR(input vsaPkg::vsaFunction fun,
                                                input logic [1:0] rd, rs1, rs2);
        vsaPkg::vsaInstr ins;
        ins.r.opcode      = vsaPkg::opAluReg;
        ins.r.source1     = rs1;
        ins.r.source2     = rs2;
        ins.r.destination = rd;
        ins.r.funct       = fun;
        return ins;
    endfunction

    // SW reads its data register from the destination slot
    function automatic vsaPkg::vsaInstr encodeI(input vsaPkg::vsaOpcode op,
                                                input logic [1:0] rd, rs1, input logic [4:0] imm);
        vsaPkg::vsaInstr ins;
        ins.i.opcode      = op;
        ins.i.source1     = rs1;
        ins.i.destination = rd;
        ins.i.immediate   = imm;
        return ins;
    endfunction

    function automatic logic [4:0] aluReference(input vsaPkg::vsaFunction fun,
                                                input logic [4:0] x, y);
        logic signed [4:0] sx;
        sx = x;
        case (fun)
            vsaPkg::funAdd:        return x + y;
            vsaPkg::funSub:        return x - y;
            vsaPkg::funAnd:        return x & y;
            vsaPkg::funOr:         return x | y;
            vsaPkg::funXor:        return x ^ y;
            vsaPkg::funNot:        return ~x;          // y not involved
            vsaPkg::funShiftRight: return x >> 1;
            default:               return sx >>> 1;    // sign bit kept
        endcase
    endfunction

    function automatic void writeModelReg(input logic [1:0] sel, input logic [4:0] value);
        if (sel != 2'd0) begin
            modelRegs[sel] = value;
        end
    endfunction

    // one instruction of the reference, gives the store and the pc that follows
    task automatic modelStep(input vsaPkg::vsaInstr ins, output vsaPkg::vsaDataWrite store,
                             output logic [4:0] nextPc);
        logic [4:0] a, b, imm, npc;
        a      = modelRegs[ins.r.source1];
        b      = modelRegs[ins.r.source2];
        imm    = ins.i.immediate;
        npc    = modelPc + 5'd2;
        store  = '0;
        nextPc = npc;
        case (ins.r.opcode)
            vsaPkg::opLoad:   writeModelReg(ins.i.destination, modelMem[a + imm]);
            vsaPkg::opStore: begin
                store.wr      = 1'b1;
                store.address = a + imm;
                store.data    = b;
                modelMem[store.address] = b;
            end
            vsaPkg::opBranchZero: begin
                if (a == 5'd0) begin
                    nextPc = npc + {imm[3:0], 1'b0};   // taken, bit 4 of imm ignored
                end
            end
            vsaPkg::opAluReg: writeModelReg(ins.r.destination, aluReference(ins.r.funct, a, b));
            vsaPkg::opAddImm: writeModelReg(ins.i.destination, a + imm);
            vsaPkg::opSubImm: writeModelReg(ins.i.destination, a - imm);
            default: ;
        endcase
        modelPc = nextPc;
    endtask

    // address and data only matter while a store is expected
    task automatic checkStore(input string name, input vsaPkg::vsaDataWrite actual,
                              input vsaPkg::vsaDataWrite expected);
        logic bad;
        bad = (actual.wr !== expected.wr);
        if (expected.wr) begin
            bad = bad || (actual !== expected);
        end
        if (bad) begin
            errorCount++;
            $display("** Error: %s wr/address/data = %h/%h/%h, expected %h/%h/%h at %0t", name,
                     actual.wr, actual.address, actual.data,
                     expected.wr, expected.address, expected.data, $time);
        end
    endtask

    task automatic checkPc(input string name, input logic [4:0] actual, input logic [4:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic void clearImages();
        progLen = 0;
        for (int a = 0; a < 32; a++) begin
            progImage[a] = encodeI(vsaPkg::opAddImm, 2'd0, 2'd0, 5'(a));  // harmless filler
        end
        for (int i = 0; i < resetCycles; i++) begin
            dataImage[i] = randWord();
        end
    endfunction

    function automatic void appendInstr(input vsaPkg::vsaInstr ins);
        progImage[2 * progLen] = ins;
        progLen++;
    endfunction

    // even program words and the low data half, one of each per reset cycle
    task automatic resetAndLoad();
        @(posedge clock);
        #2;
        reset = 1'b1;
        for (int i = 0; i < resetCycles; i++) begin
            progLoad.valid   = 1'b1;
            progLoad.address = 5'(2 * i);
            progLoad.instr   = progImage[2 * i];
            dataLoad.valid   = 1'b1;
            dataLoad.address = 5'(i);
            dataLoad.data    = dataImage[i];
            modelMem[i]      = dataImage[i];
            @(posedge clock);
            #2;
        end
        progLoad = '0;
        dataLoad = '0;
        reset    = 1'b0;
        modelPc  = '0;
        for (int r = 0; r < 4; r++) begin
            modelRegs[r] = '0;
        end
    endtask

    // cycle c belongs to instruction c/5, sampled mid cycle
    task automatic runProgram(input int instrCount);
        vsaPkg::vsaDataWrite expStore, idle;
        logic [4:0] pcBefore, pcAfter;
        int phase;
        idle     = '0;
        expStore = '0;
        pcBefore = '0;
        pcAfter  = '0;
        resetAndLoad();
        for (int c = 0; c < 5 * instrCount; c++) begin
            phase = c % 5;
            @(negedge clock);
            if (phase == 0) begin
                pcBefore = modelPc;
                modelStep(progImage[modelPc], expStore, pcAfter);
            end
            checkStore("storeOut", storeOut, (phase == 3) ? expStore : idle);
            checkPc("pc", pc, (phase == 4) ? pcAfter : pcBefore);   // pc moves at end of mem
        end
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d errors", testCount, name, errorCount - startErrors);
        end
    endtask

    task automatic resetState();
        int startErrors;
        vsaPkg::vsaOpcode op;
        startErrors = errorCount;
        clearImages();
        for (int k = 0; k < lenReset; k++) begin       // no stores, no branches
            if (k % 2 == 0) begin
                op = vsaPkg::opAddImm;
            end else begin
                op = vsaPkg::opSubImm;
            end
            appendInstr(encodeI(op, 2'(1 + k % 3), 2'(k % 4), randWord()));
        end
        runProgram(lenReset);
        finishTest("reset state and pc sequence", startErrors);
    endtask

    task automatic immediateArith();
        int startErrors;
        startErrors = errorCount;
        clearImages();
        appendInstr(encodeI(vsaPkg::opAddImm, 2'd1, 2'd0, randWord()));
        appendInstr(encodeI(vsaPkg::opAddImm, 2'd2, 2'd1, randWord()));
        appendInstr(encodeI(vsaPkg::opSubImm, 2'd3, 2'd2, randWord()));
        appendInstr(encodeI(vsaPkg::opStore, 2'd1, 2'd0, randWord()));
        appendInstr(encodeI(vsaPkg::opStore, 2'd2, 2'd0, randWord()));
        appendInstr(encodeI(vsaPkg::opStore, 2'd3, 2'd0, randWord()));
        appendInstr(encodeI(vsaPkg::opSubImm, 2'd1, 2'd3, randWord()));
        appendInstr(encodeI(vsaPkg::opStore, 2'd1, 2'd2, randWord()));   // base from R2
        appendInstr(encodeI(vsaPkg::opAddImm, 2'd2, 2'd2, 5'h1f));       // wraps
        appendInstr(encodeI(vsaPkg::opStore, 2'd2, 2'd3, randWord()));
        runProgram(lenImm);
        finishTest("immediate arithmetic and store", startErrors);
    endtask

    task automatic aluRun(input int firstFun);
        vsaPkg::vsaFunction fun;
        clearImages();
        appendInstr(encodeI(vsaPkg::opAddImm, 2'd1, 2'd0, randWord() | 5'h10));  // msb set
        appendInstr(encodeI(vsaPkg::opAddImm, 2'd2, 2'd0, randWord()));
        for (int j = 0; j < 4; j++) begin
            fun = vsaPkg::vsaFunction'(3'(firstFun + j));
            appendInstr(encodeR(fun, 2'd3, 2'd1, 2'd2));
            appendInstr(encodeI(vsaPkg::opStore, 2'd3, 2'd0, 5'(8 * j + firstFun)));
        end
        runProgram(lenAlu);
    endtask

    task automatic aluGroup();
        int startErrors;
        startErrors = errorCount;
        aluRun(0);
        aluRun(4);          // NOT and both shifts
        finishTest("R-format group", startErrors);
    endtask

    task automatic loadPath();
        int startErrors;
        startErrors = errorCount;
        clearImages();
        for (int r = 1; r < 4; r++) begin
            appendInstr(encodeI(vsaPkg::opLoad, 2'(r), 2'd0, randWord() & 5'h0f));  // preloaded half
        end
        for (int r = 1; r < 4; r++) begin
            appendInstr(encodeI(vsaPkg::opStore, 2'(r), 2'd0, 5'(16 + 5 * r)));
        end
        runProgram(lenLoad);
        finishTest("load path", startErrors);
    endtask

    task automatic branchPaths();
        int startErrors;
        startErrors = errorCount;
        clearImages();
        progImage[0]  = encodeI(vsaPkg::opAddImm, 2'd1, 2'd0, randWord() | 5'h01);  // nonzero
        progImage[2]  = encodeI(vsaPkg::opBranchZero, 2'd0, 2'd1, 5'h03);  // not taken
        progImage[4]  = encodeI(vsaPkg::opStore, 2'd1, 2'd0, 5'd20);      // marker runs
        progImage[6]  = encodeI(vsaPkg::opBranchZero, 2'd0, 2'd2, 5'h11);  // taken to 10
        progImage[8]  = encodeI(vsaPkg::opStore, 2'd1, 2'd0, 5'd21);      // marker skipped
        progImage[10] = encodeI(vsaPkg::opStore, 2'd1, 2'd0, 5'd22);
        progImage[12] = encodeI(vsaPkg::opStore, 2'd2, 2'd0, 5'd23);
        runProgram(lenBranch);
        finishTest("branches", startErrors);
    endtask

    task automatic registerZero();
        int startErrors;
        startErrors = errorCount;
        clearImages();
        progImage[0]  = encodeI(vsaPkg::opAddImm, 2'd1, 2'd0, randWord() | 5'h01);
        progImage[2]  = encodeI(vsaPkg::opAddImm, 2'd0, 2'd1, randWord());       // dropped
        progImage[4]  = encodeR(vsaPkg::funAdd, 2'd0, 2'd1, 2'd1);               // dropped
        progImage[6]  = encodeI(vsaPkg::opLoad, 2'd0, 2'd0, randWord() & 5'h0f); // dropped
        progImage[8]  = encodeI(vsaPkg::opStore, 2'd0, 2'd0, 5'd24);             // stores zero
        progImage[10] = encodeI(vsaPkg::opBranchZero, 2'd0, 2'd0, 5'h02);        // to 16
        progImage[12] = encodeI(vsaPkg::opStore, 2'd1, 2'd0, 5'd25);
        progImage[16] = encodeI(vsaPkg::opStore, 2'd0, 2'd1, 5'd0);
        runProgram(lenZero);
        finishTest("register zero", startErrors);
    endtask

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clock    = 1'b0;
        reset    = 1'b1;
        progLoad = '0;
        dataLoad = '0;
        resetState();
        immediateArith();
        aluGroup();
        loadPath();
        branchPaths();
        registerZero();
        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
